// File: design/cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_regs (
  input  wire                                   CLK,
  input  wire                                   resetn,
  input  wire  [7:0]                            rx_byte,
  input  wire                                   rx_valid,
  input  wire                                   frame_start,
  input  wire  signed [motor_pkg::enc_w-1:0]    enc_count,
  input  wire                                   enc_fault,
  input  wire                                   move_done,
  output logic [7:0]                            tx_byte,
  output logic                                  enable,
  output motor_pkg::step_mode_e                 step_mode,
  output logic                                  move_start,
  output logic                                  move_dir,
  output logic [motor_pkg::step_cnt_w-1:0]      move_steps,
  output logic [motor_pkg::step_per_w-1:0]      move_period
);

  logic [2:0]                byte_cnt;
  spi_cmd_pkg::cmd_op_e      op;
  logic [23:0]               pay_q;       // First three payload bytes
  logic [31:0]               rb_word;
  spi_cmd_pkg::cmd_payload_u word;
  logic                      last_byte;

  // Full payload as it stands when the fifth byte arrives
  assign word      = {pay_q, rx_byte};
  assign last_byte = rx_valid && (byte_cnt == 3'(spi_cmd_pkg::frame_bytes - 1));

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      byte_cnt   <= 3'd0;
      enable     <= 1'b0;
      step_mode  <= motor_pkg::step_full;
      move_start <= 1'b0;
    end else begin
      move_start <= 1'b0;
      if (frame_start)
        byte_cnt <= 3'd0;
      else if (rx_valid && byte_cnt != 3'(spi_cmd_pkg::frame_bytes))
        byte_cnt <= byte_cnt + 3'd1;  // Extra bytes park here
      if (last_byte && !frame_start) begin
        if (op == spi_cmd_pkg::op_config) begin
          enable    <= word.cfg.enable;
          step_mode <= word.cfg.step_mode;
        end
        if (op == spi_cmd_pkg::op_move)
          move_start <= 1'b1;  // step_gen decides whether to take it
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_valid && byte_cnt == 3'd0) begin
      op <= spi_cmd_pkg::cmd_op_e'(rx_byte);
      // Read-back snapshot taken at the opcode byte
      case (spi_cmd_pkg::cmd_op_e'(rx_byte))
        spi_cmd_pkg::op_read_enc:    rb_word <= enc_count;
        spi_cmd_pkg::op_read_status: rb_word <= {30'd0, enc_fault, move_done};
        default:                     rb_word <= 32'd0;
      endcase
    end
    if (rx_valid && byte_cnt != 3'd0)
      pay_q <= {pay_q[15:0], rx_byte};
    if (last_byte) begin
      move_dir    <= word.mv.dir;
      move_steps  <= word.mv.steps;
      move_period <= word.mv.period;
    end
  end

  // Byte for the next transfer, valid the cycle after rx_valid
  always_comb begin
    case (byte_cnt)
      3'd1:    tx_byte = rb_word[31:24];
      3'd2:    tx_byte = rb_word[23:16];
      3'd3:    tx_byte = rb_word[15:8];
      3'd4:    tx_byte = rb_word[7:0];
      default: tx_byte = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// File: design/motor_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module motor_ctrl_top (
  input  wire  CLK,
  input  wire  resetn,
  input  wire  sck,
  input  wire  cs,
  input  wire  copi,
  input  wire  enc_a,
  input  wire  enc_b,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step_out,
  output logic move_done
);

  logic [7:0]                              rx_byte;
  logic                                    rx_valid;
  logic                                    frame_start;
  logic [7:0]                              tx_byte;
  logic                                    enable;
  motor_pkg::step_mode_e                   step_mode;
  logic                                    move_start;
  logic                                    move_dir;
  logic [motor_pkg::step_cnt_w-1:0]        move_steps;
  logic [motor_pkg::step_per_w-1:0]        move_period;
  logic                                    step_dir;
  logic signed [motor_pkg::enc_w-1:0]      enc_count;
  logic                                    enc_fault;

  spi_target spi0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .sck         (sck),
    .cs          (cs),
    .copi        (copi),
    .tx_byte     (tx_byte),
    .cipo        (cipo),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start)
  );

  cmd_regs regs0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .enc_count   (enc_count),
    .enc_fault   (enc_fault),
    .move_done   (move_done),
    .tx_byte     (tx_byte),
    .enable      (enable),
    .step_mode   (step_mode),
    .move_start  (move_start),
    .move_dir    (move_dir),
    .move_steps  (move_steps),
    .move_period (move_period)
  );

  // Step pulse also drives the step pin
  step_gen stepper0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .move_start  (move_start),
    .move_dir    (move_dir),
    .move_steps  (move_steps),
    .move_period (move_period),
    .step_pulse  (step_out),
    .step_dir    (step_dir),
    .move_done   (move_done)
  );

  phase_seq bridge0 (
    .CLK        (CLK),
    .resetn     (resetn),
    .step_pulse (step_out),
    .step_dir   (step_dir),
    .enable     (enable),
    .step_mode  (step_mode),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  quad_enc encoder0 (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .count  (enc_count),
    .fault  (enc_fault)
  );

endmodule

`default_nettype wire

// File: design/motor_pkg.sv
`default_nettype none

package motor_pkg;

  // Full-step walks the phase table two entries per step
  typedef enum logic [0:0] {
    step_full = 1'b0,
    step_half = 1'b1
  } step_mode_e;

  // A1 A2 B1 B2
  localparam int phase_w = 4;

  // Signed encoder count
  localparam int enc_w = 32;

  // Steps in one move
  localparam int step_cnt_w = 16;

  // Step period in CLK cycles
  localparam int step_per_w = 15;

endpackage

`default_nettype wire

// File: design/phase_seq.sv
`timescale 1ns/1ps
`default_nettype none

module phase_seq (
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire                   step_pulse,
  input  wire                   step_dir,
  input  wire                   enable,
  input  motor_pkg::step_mode_e step_mode,
  output logic                  phase_a1,
  output logic                  phase_a2,
  output logic                  phase_b1,
  output logic                  phase_b2
);

  logic [2:0]                   pos;
  logic [2:0]                   pos_nxt;
  logic [2:0]                   pos_inc;
  logic [motor_pkg::phase_w-1:0] drive;

  // Standard half-step table, A1 A2 B1 B2
  function automatic logic [motor_pkg::phase_w-1:0] pattern(input logic [2:0] p);
    case (p)
      3'd0: pattern = 4'b1000;
      3'd1: pattern = 4'b1010;
      3'd2: pattern = 4'b0010;
      3'd3: pattern = 4'b0110;
      3'd4: pattern = 4'b0100;
      3'd5: pattern = 4'b0101;
      3'd6: pattern = 4'b0001;
      default: pattern = 4'b1001;
    endcase
  endfunction

  assign pos_inc = (step_mode == motor_pkg::step_half) ? 3'd1 : 3'd2;

  always_comb begin
    pos_nxt = pos;
    if (step_pulse)
      pos_nxt = step_dir ? pos + pos_inc : pos - pos_inc;  // Wraps mod 8
  end

  // Position still tracks steps while the bridge is off
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pos   <= 3'd0;
      drive <= '0;
    end else begin
      pos   <= pos_nxt;
      drive <= enable ? pattern(pos_nxt) : '0;
    end
  end

  assign {phase_a1, phase_a2, phase_b1, phase_b2} = drive;

endmodule

`default_nettype wire

// File: design/quad_enc.sv
`timescale 1ns/1ps
`default_nettype none

module quad_enc (
  input  wire                                 CLK,
  input  wire                                 resetn,
  input  wire                                 enc_a,
  input  wire                                 enc_b,
  output logic signed [motor_pkg::enc_w-1:0]  count,
  output logic                                fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] ab;
  logic [1:0] ab_q;
  logic [1:0] ab_chg;

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
  end

  assign ab     = {a_sync[1], b_sync[1]};
  assign ab_chg = ab ^ ab_q;

  always_ff @(posedge CLK) begin
    ab_q <= ab;  // Tracks pins during reset too
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else if (^ab_chg) begin
      // 4x decode where old A against new B gives direction
      if (ab_q[1] ^ ab[0])
        count <= count - 1;
      else
        count <= count + 1;  // A leads B
    end else if (&ab_chg) begin
      fault <= 1'b1;  // Sticky skipped-state flag
    end
  end

endmodule

`default_nettype wire

// File: design/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  typedef enum logic [7:0] {
    op_config      = 8'h01,
    op_move        = 8'h02,
    op_read_enc    = 8'h03,
    op_read_status = 8'h04
  } cmd_op_e;

  // Opcode byte plus four payload bytes, MSB first
  localparam int frame_bytes = 5;

  typedef struct packed {
    logic [29:0]          rsvd;
    motor_pkg::step_mode_e step_mode;
    logic                 enable;
  } cfg_word_t;

  typedef struct packed {
    logic                                dir;     // 1 counts phase position up
    logic [motor_pkg::step_per_w-1:0]    period;
    logic [motor_pkg::step_cnt_w-1:0]    steps;
  } move_word_t;

  // Same 32 payload bits, read according to the opcode
  typedef union packed {
    cfg_word_t  cfg;
    move_word_t mv;
  } cmd_payload_u;

endpackage

`default_nettype wire

// File: design/spi_target.sv
`timescale 1ns/1ps
`default_nettype none

module spi_target (
  input  wire        CLK,
  input  wire        resetn,
  input  wire        sck,
  input  wire        cs,
  input  wire        copi,
  input  wire  [7:0] tx_byte,
  output logic       cipo,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       frame_start
);

  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_q;
  logic       cs_q;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [6:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;

  // Two-flop synchronizers, SCK must be slow against CLK
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync    <= 2'b00;
      cs_sync     <= 2'b11;
      sck_q       <= 1'b0;
      cs_q        <= 1'b1;
      frame_start <= 1'b0;
    end else begin
      sck_sync    <= {sck_sync[0], sck};
      cs_sync     <= {cs_sync[0], cs};
      sck_q       <= sck_sync[1];
      cs_q        <= cs_sync[1];
      frame_start <= cs_q & ~cs_sync[1];  // CS falling
    end
  end

  always_ff @(posedge CLK) begin
    copi_sync <= {copi_sync[0], copi};
  end

  assign sck_rise = sck_sync[1] & ~sck_q;
  assign sck_fall = ~sck_sync[1] & sck_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
      cipo     <= 1'b0;
      tx_shift <= 7'd0;
    end else begin
      rx_valid <= 1'b0;
      if (cs_sync[1]) begin
        bit_cnt  <= 3'd0;
        cipo     <= 1'b0;
        tx_shift <= 7'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          rx_valid <= 1'b1;
      end else if (sck_fall) begin
        if (bit_cnt == 3'd0) begin  // Byte boundary, take next byte
          cipo     <= tx_byte[7];
          tx_shift <= tx_byte[6:0];
        end else begin
          cipo     <= tx_shift[6];
          tx_shift <= {tx_shift[5:0], 1'b0};
        end
      end
    end
  end

  // COPI sampled on SCK rise, MSB first
  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[5:0], copi_sync[1]};
      if (bit_cnt == 3'd7)
        rx_byte <= {rx_shift, copi_sync[1]};
    end
  end

endmodule

`default_nettype wire

// File: design/step_gen.sv
`timescale 1ns/1ps
`default_nettype none

module step_gen (
  input  wire                               CLK,
  input  wire                               resetn,
  input  wire                               move_start,
  input  wire                               move_dir,
  input  wire [motor_pkg::step_cnt_w-1:0]   move_steps,
  input  wire [motor_pkg::step_per_w-1:0]   move_period,
  output logic                              step_pulse,
  output logic                              step_dir,
  output logic                              move_done
);

  logic                              busy;
  logic [motor_pkg::step_per_w-1:0]  per_cnt;    // Cycles to next pulse
  logic [motor_pkg::step_per_w-1:0]  period;
  logic [motor_pkg::step_cnt_w-1:0]  steps_left;

  // Pulse on the last cycle of each period
  assign step_pulse = busy && (per_cnt == 1);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      move_done <= 1'b1;
    end else if (!busy) begin
      if (move_start && move_steps != '0) begin  // Zero steps is done at once
        busy      <= 1'b1;
        move_done <= 1'b0;
      end
    end else if (step_pulse && steps_left == 1) begin
      busy      <= 1'b0;
      move_done <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!busy) begin
      if (move_start) begin
        per_cnt    <= move_period;
        period     <= move_period;
        steps_left <= move_steps;
        step_dir   <= move_dir;
      end
    end else if (step_pulse) begin
      per_cnt    <= period;
      steps_left <= steps_left - 1'b1;
    end else begin
      per_cnt <= per_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: list.f
design/motor_pkg.sv
design/spi_cmd_pkg.sv
design/spi_target.sv
design/cmd_regs.sv
design/step_gen.sv
design/phase_seq.sv
design/quad_enc.sv
design/motor_ctrl_top.sv
test/tb_clkgen.sv
test/tb_motor_ctrl.sv

// File: test/motor_patterns.txt
# Columns: name op arg0 arg1 expected, all numbers in hex
# config: arg0 payload / move: arg0 move word, arg1 overlapping move word, expected phase
# encoder: arg0 edge count, arg1 adds a double change / read_enc: checked against encoder model
status_reset   read_status  00000000  00000000  00000001
cfg_full       config       00000001  00000000  00000000
move_full_up   move         80640003  00000000  00000001
cfg_half       config       00000003  00000000  00000000
move_half_up   move         80280005  00000000  00000006
move_half_dn   move         00280007  00000000  00000004
move_overlap   move         80780006  80780004  00000002
enc_walk       encoder      00000028  00000000  00000000
enc_read       read_enc     00000000  00000000  00000000
enc_fault      encoder      00000000  00000001  00000000
status_fault   read_status  00000000  00000000  00000003
enc_more       encoder      0000000c  00000000  00000000
enc_read2      read_enc     00000000  00000000  00000000
cfg_off        config       00000000  00000000  00000000
move_off       move         801e0004  00000000  00000000
status_end     read_status  00000000  00000000  00000003

// File: test/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns period
  end

  // Reset held for three rising edges
  initial begin
    resetn = 1'b0;
    repeat (3) @(posedge CLK);
    resetn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_motor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_motor_ctrl;

  localparam int max_tests    = 64;
  localparam int frame_cycles = 400;  // 40 SCK bits of 8 CLK each plus CS setup and hold
  localparam int enc_gap      = 6;    // Count moves 3 cycles after a pin edge

  wire  CLK;
  wire  resetn;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  wire  cipo;
  wire  phase_a1;
  wire  phase_a2;
  wire  phase_b1;
  wire  phase_b2;
  wire  step_out;
  wire  move_done;

  logic [127:0] t_name [0:max_tests-1];
  logic [127:0] t_op   [0:max_tests-1];
  logic [31:0]  t_arg0 [0:max_tests-1];
  logic [31:0]  t_arg1 [0:max_tests-1];
  logic [31:0]  t_exp  [0:max_tests-1];
  int           num_tests   = 0;
  int           cycles      = 0;
  int           cycle_limit = 0;
  int           pulse_cnt   = 0;
  int           test_errs   = 0;
  int           passed      = 0;
  int           failed      = 0;
  int           enc_model   = 0;   // Expected signed encoder count
  logic [1:0]   gray_idx    = 2'd0;
  logic [31:0]  lcg_state   = 32'd53809;

  tb_clkgen clkgen0 (
    .CLK    (CLK),
    .resetn (resetn)
  );

  motor_ctrl_top dut0 (
    .CLK       (CLK),
    .resetn    (resetn),
    .sck       (sck),
    .cs        (cs),
    .copi      (copi),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .cipo      (cipo),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .step_out  (step_out),
    .move_done (move_done)
  );

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles, a test never finished", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // One-cycle pulses counted away from the active edge
  always @(negedge CLK) begin
    if (step_out)
      pulse_cnt <= pulse_cnt + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Forward order 00 10 11 01 with A leading B
  function automatic logic [1:0] quad_state(input logic [1:0] idx);
    case (idx)
      2'd0:    return 2'b00;
      2'd1:    return 2'b10;
      2'd2:    return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check_value(input logic [127:0] tname, input string what,
                             input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("Error %0s %0s: expected 0x%h, actual 0x%h", tname, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic report(input logic [127:0] tname);
    if (test_errs == 0) begin
      passed++;
      $display("%0s: ok", tname);
    end else begin
      failed++;
      $display("%0s: failed with %0d errors", tname, test_errs);
    end
  endtask

  task automatic load_patterns;
    int            fd;
    int            n;
    logic [1279:0] line;
    logic [127:0]  nm;
    logic [127:0]  op;
    logic [31:0]   a0;
    logic [31:0]   a1;
    logic [31:0]   ex;
    fd = $fopen("test/motor_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/motor_patterns.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%s %s %h %h %h", nm, op, a0, a1, ex);
        if (n == 5 && nm != "#" && num_tests < max_tests) begin  // Comments never parse fully
          t_name[num_tests] = nm;
          t_op[num_tests]   = op;
          t_arg0[num_tests] = a0;
          t_arg1[num_tests] = a1;
          t_exp[num_tests]  = ex;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Mode 0 bit with CIPO taken just before SCK rises
  task automatic spi_bit(input logic b, output logic r);
    @(posedge CLK);
    copi <= b;
    sck  <= 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    r = cipo;
    @(posedge CLK);
    sck <= 1'b1;
    repeat (3) @(posedge CLK);
  endtask

  task automatic spi_frame(input logic [7:0] op, input logic [31:0] payload,
                           output logic [31:0] rb);
    logic [39:0] tx;
    logic [39:0] rx;
    logic        r;
    int          k;
    tx = {op, payload};
    @(posedge CLK);
    cs <= 1'b0;
    repeat (4) @(posedge CLK);
    for (k = 39; k >= 0; k--) begin
      spi_bit(tx[k], r);
      rx[k] = r;
    end
    @(posedge CLK);
    sck <= 1'b0;
    repeat (4) @(posedge CLK);
    cs <= 1'b1;
    repeat (8) @(posedge CLK);
    rb = rx[31:0];  // Opcode byte returns nothing
  endtask

  task automatic run_move(input int i);
    logic [31:0] rb;
    logic        bridge_on;
    int          start_cnt;
    int          steps;
    steps     = t_arg0[i][15:0];
    start_cnt = pulse_cnt;
    bridge_on = 1'b0;
    spi_frame(spi_cmd_pkg::op_move, t_arg0[i], rb);
    @(negedge CLK);
    check_value(t_name[i], "move_done while moving", 32'd0, move_done);
    if (t_arg1[i] != 0)
      spi_frame(spi_cmd_pkg::op_move, t_arg1[i], rb);  // Lands while the first move runs
    while (move_done !== 1'b1) begin
      if (t_exp[i] == 0 && {phase_a1, phase_a2, phase_b1, phase_b2} != 4'd0)
        bridge_on = 1'b1;  // Disabled bridge must stay dark
      @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    check_value(t_name[i], "phase during move", 32'd0, bridge_on);
    check_value(t_name[i], "step pulses", steps, pulse_cnt - start_cnt);
    check_value(t_name[i], "phase", t_exp[i], {phase_a1, phase_a2, phase_b1, phase_b2});
  endtask

  task automatic drive_encoder(input int edges, input logic glitch);
    int k;
    for (k = 0; k < edges; k++) begin
      lcg_state = lcg_next(lcg_state);
      if (lcg_state[16]) begin
        gray_idx = gray_idx + 2'd1;
        enc_model++;
      end else begin
        gray_idx = gray_idx - 2'd1;
        enc_model--;
      end
      @(posedge CLK);
      {enc_a, enc_b} <= quad_state(gray_idx);
      repeat (enc_gap) @(posedge CLK);
    end
    if (glitch) begin
      gray_idx = gray_idx + 2'd2;  // Both pins flip and the count holds
      @(posedge CLK);
      {enc_a, enc_b} <= quad_state(gray_idx);
      repeat (enc_gap) @(posedge CLK);
    end
  endtask

  initial begin
    logic [31:0] rb;
    int          i;
    int          limit;
    sck   = 1'b0;
    cs    = 1'b1;
    copi  = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    load_patterns();
    limit = 2000;
    for (i = 0; i < num_tests; i++) begin
      limit += frame_cycles;
      if (t_op[i] == "move")
        limit += int'(t_arg0[i][15:0]) * (int'(t_arg0[i][30:16]) + 1)
                 + ((t_arg1[i] != 0) ? frame_cycles : 0);
      if (t_op[i] == "encoder")
        limit += int'(t_arg0[i] + t_arg1[i]) * (enc_gap + 1);
    end
    cycle_limit = limit;
    wait (resetn === 1'b1);
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    check_value("after_reset", "phase", 32'd0, {phase_a1, phase_a2, phase_b1, phase_b2});
    check_value("after_reset", "move_done", 32'd1, move_done);
    report("after_reset");
    if (num_tests == 0) begin
      $display("No tests found in test/motor_patterns.txt");
      failed++;
    end
    for (i = 0; i < num_tests; i++) begin
      test_errs = 0;
      if (t_op[i] == "config") begin
        spi_frame(spi_cmd_pkg::op_config, t_arg0[i], rb);
        check_value(t_name[i], "read-back", 32'd0, rb);
      end else if (t_op[i] == "move") begin
        run_move(i);
      end else if (t_op[i] == "encoder") begin
        drive_encoder(t_arg0[i], t_arg1[i][0]);
      end else if (t_op[i] == "read_enc") begin
        spi_frame(spi_cmd_pkg::op_read_enc, 32'd0, rb);
        check_value(t_name[i], "count", enc_model, rb);
      end else if (t_op[i] == "read_status") begin
        spi_frame(spi_cmd_pkg::op_read_status, 32'd0, rb);
        check_value(t_name[i], "status", t_exp[i], rb);
      end else begin
        $display("Test %0s has an unknown operation %0s", t_name[i], t_op[i]);
        test_errs++;
      end
      report(t_name[i]);
    end
    $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
